// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= vcache_tile_tb
LOG ?= sim.log
FILELIST ?= vcache_tile.f
BUILD ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "variables: VERILATOR TOP LOG FILELIST BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== rtl/vcache_cache.sv ====
/*
 * direct-mapped write-back cache
 * 8 sets of 4-word blocks, misses go out as writeback and fill DMA
 */
`timescale 1ns/100ps

module vcache_cache
  import vcache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,

  input  logic        req_v_i,
  input  logic        req_store_i,
  input  word_addr_t  req_addr_i,
  input  data_t       req_data_i,
  output logic        req_yumi_o,
  output logic        resp_v_o,
  output data_t       resp_data_o,
  input  logic        resp_yumi_i,

  output logic        dma_v_o,
  output logic        dma_write_o,
  output block_addr_t dma_addr_o,
  input  logic        dma_yumi_i,
  output data_t       dma_wdata_o,
  input  logic        dma_wdata_yumi_i,
  input  logic        dma_rdata_v_i,
  input  data_t       dma_rdata_i
);

  cache_state_e state_r;
  data_t data_mem [cache_sets*block_words];
  tag_t tag_mem [cache_sets];
  logic [cache_sets-1:0] valid_r, dirty_r;

  logic store_r;
  word_addr_t addr_r;
  data_t wdata_r, resp_data_r;
  offset_t cnt_r;
  index_t idx;
  tag_t tag;
  offset_t off;
  logic hit, last;

  assign idx = addr_r[offset_bits +: index_bits];
  assign tag = addr_r[offset_bits+index_bits +: tag_bits];
  assign off = addr_r[offset_bits-1:0];
  assign hit = valid_r[idx] && (tag_mem[idx] == tag);
  assign last = cnt_r == offset_t'(block_words - 1);

  assign req_yumi_o = (state_r == c_idle) && req_v_i;
  assign resp_v_o = state_r == c_respond;
  assign resp_data_o = resp_data_r;

  // dirty victim goes out first, the fill follows on the retried lookup
  assign dma_v_o = (state_r == c_lookup) && !hit;
  assign dma_write_o = dirty_r[idx];
  assign dma_addr_o = dirty_r[idx] ? {tag_mem[idx], idx} : {tag, idx};
  assign dma_wdata_o = data_mem[{idx, cnt_r}];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= c_idle;
      valid_r <= '0;
      dirty_r <= '0;
      cnt_r <= '0;
    end else begin
      case (state_r)
        c_idle: begin
          if (req_v_i) state_r <= c_lookup;
        end
        c_lookup: begin
          if (hit) begin
            if (store_r) dirty_r[idx] <= 1'b1;
            state_r <= c_respond;
          end else if (dma_yumi_i) begin
            state_r <= dirty_r[idx] ? c_evict : c_fill;
          end
        end
        c_evict: begin
          if (dma_wdata_yumi_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last) begin
              dirty_r[idx] <= 1'b0;
              state_r <= c_lookup;
            end
          end
        end
        c_fill: begin
          if (dma_rdata_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last) begin
              valid_r[idx] <= 1'b1;
              state_r <= c_lookup;
            end
          end
        end
        c_respond: begin
          if (resp_yumi_i) state_r <= c_idle;
        end
        default: state_r <= c_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_yumi_o) begin
      store_r <= req_store_i;
      addr_r <= req_addr_i;
      wdata_r <= req_data_i;
    end
    if ((state_r == c_lookup) && hit) begin
      if (store_r) data_mem[{idx, off}] <= wdata_r;
      resp_data_r <= data_mem[{idx, off}];
    end
    // fill words arrive in offset order
    if ((state_r == c_fill) && dma_rdata_v_i) begin
      data_mem[{idx, cnt_r}] <= dma_rdata_i;
      if (last) tag_mem[idx] <= tag;
    end
  end

  a_fill_state: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_rdata_v_i |-> state_r == c_fill);

endmodule

// ==== rtl/vcache_dma_to_wormhole.sv ====
/*
 * cache DMA to wormhole adapter
 * sends fill and writeback headers east or west and collects fill words
 */
`timescale 1ns/100ps

module vcache_dma_to_wormhole
  import vcache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  cord_x_t     my_x_i,
  input  logic        my_cid_i,

  input  logic        dma_v_i,
  input  logic        dma_write_i,
  input  block_addr_t dma_addr_i,
  output logic        dma_yumi_o,
  input  data_t       dma_wdata_i,
  output logic        dma_wdata_yumi_o,
  output logic        dma_rdata_v_o,
  output data_t       dma_rdata_o,

  output logic        wh_e_v_o,
  output flit_t       wh_e_flit_o,
  input  logic        wh_e_ready_i,
  input  logic        wh_e_v_i,
  input  flit_t       wh_e_flit_i,
  output logic        wh_e_ready_o,

  output logic        wh_w_v_o,
  output flit_t       wh_w_flit_o,
  input  logic        wh_w_ready_i,
  input  logic        wh_w_v_i,
  input  flit_t       wh_w_flit_i,
  output logic        wh_w_ready_o
);

  dma_state_e state_r;
  logic write_r, east_r, hdr_seen_r;
  block_addr_t addr_r;
  offset_t cnt_r;
  logic send_v, out_ready, sent, in_v, recv, hdr_match, last;
  flit_t header, send_flit, in_flit;

  always_comb begin
    header = '0;
    header[3:0] = east_r ? cord_x_t'(mem_east_cord) : cord_x_t'(mem_west_cord);
    header[flit_len_lsb +: 4] = write_r ? 4'(block_words) : 4'd0;
    header[flit_cid_bit] = my_cid_i;
    header[flit_write_bit] = write_r;
    header[flit_addr_lsb +: $bits(block_addr_t)] = addr_r;
  end

  assign send_v = (state_r == d_header) || (state_r == d_wdata);
  assign send_flit = (state_r == d_header) ? header : dma_wdata_i;
  assign out_ready = east_r ? wh_e_ready_i : wh_w_ready_i;
  assign sent = send_v && out_ready;
  assign in_v = east_r ? wh_e_v_i : wh_w_v_i;
  assign in_flit = east_r ? wh_e_flit_i : wh_w_flit_i;
  assign recv = (state_r == d_rdata) && in_v;
  // reply header must come back to our column and cid
  assign hdr_match = (in_flit[3:0] == my_x_i) && (in_flit[flit_cid_bit] == my_cid_i);
  assign last = cnt_r == offset_t'(block_words - 1);

  assign wh_e_v_o = send_v && east_r;
  assign wh_w_v_o = send_v && !east_r;
  assign wh_e_flit_o = send_flit;
  assign wh_w_flit_o = send_flit;
  assign wh_e_ready_o = (state_r == d_rdata) && east_r;
  assign wh_w_ready_o = (state_r == d_rdata) && !east_r;

  assign dma_yumi_o = (state_r == d_idle) && dma_v_i;
  assign dma_wdata_yumi_o = (state_r == d_wdata) && out_ready;
  assign dma_rdata_v_o = recv && hdr_seen_r;
  assign dma_rdata_o = in_flit;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= d_idle;
      cnt_r <= '0;
      hdr_seen_r <= 1'b0;
    end else begin
      case (state_r)
        d_idle: begin
          if (dma_v_i) state_r <= d_header;
        end
        d_header: begin
          if (sent) state_r <= write_r ? d_wdata : d_rdata;
        end
        d_wdata: begin
          if (sent) begin
            cnt_r <= cnt_r + 1'b1;
            if (last) state_r <= d_done;
          end
        end
        d_rdata: begin
          if (recv && !hdr_seen_r) begin
            hdr_seen_r <= hdr_match;
          end else if (recv) begin
            cnt_r <= cnt_r + 1'b1;
            if (last) begin
              hdr_seen_r <= 1'b0;
              state_r <= d_done;
            end
          end
        end
        d_done: state_r <= d_idle;
        default: state_r <= d_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_yumi_o) begin
      write_r <= dma_write_i;
      addr_r <= dma_addr_i;
      east_r <= dma_addr_i[$bits(block_addr_t)-1];
    end
  end

  a_hold_e: assert property (@(posedge clk_i) disable iff (rst_i)
    (wh_e_v_o && !wh_e_ready_i) |=> wh_e_v_o);
  a_hold_w: assert property (@(posedge clk_i) disable iff (rst_i)
    (wh_w_v_o && !wh_w_ready_i) |=> wh_w_v_o);

endmodule

// ==== rtl/vcache_link_to_cache.sv ====
/*
 * link to cache adapter
 * turns one mesh request into a cache request and builds its response packet
 */
`timescale 1ns/100ps

module vcache_link_to_cache
  import vcache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  cord_y_t    my_y_i,

  input  logic       pkt_v_i,
  input  link_pkt_t  pkt_i,
  output logic       pkt_ready_o,
  output logic       pkt_v_o,
  output link_pkt_t  pkt_o,
  input  logic       pkt_ready_i,

  output logic       req_v_o,
  output logic       req_store_o,
  output word_addr_t req_addr_o,
  output data_t      req_data_o,
  input  logic       req_yumi_i,
  input  logic       resp_v_i,
  input  data_t      resp_data_i,
  output logic       resp_yumi_o
);

  logic busy_r, req_v_r, out_v_r, store_r;
  word_addr_t addr_r;
  data_t data_r, out_data_r;
  cord_y_t src_r;
  logic take;

  // one request in flight until its response leaves
  assign pkt_ready_o = !busy_r;
  assign take = pkt_v_i && !busy_r;
  assign resp_yumi_o = resp_v_i && busy_r && !req_v_r && !out_v_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_r <= 1'b0;
      req_v_r <= 1'b0;
      out_v_r <= 1'b0;
    end else begin
      if (take) begin
        busy_r <= 1'b1;
        req_v_r <= 1'b1;
      end
      if (req_yumi_i) req_v_r <= 1'b0;
      if (resp_yumi_o) out_v_r <= 1'b1;
      if (out_v_r && pkt_ready_i) begin
        out_v_r <= 1'b0;
        busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      store_r <= pkt_i[link_store_bit];
      addr_r <= pkt_i[link_addr_lsb +: $bits(word_addr_t)];
      data_r <= pkt_i[link_data_lsb +: $bits(data_t)];
      src_r <= pkt_i[link_src_lsb +: $bits(cord_y_t)];
    end
    // stores echo their data as the ack
    if (resp_yumi_o) out_data_r <= store_r ? data_r : resp_data_i;
  end

  assign req_v_o = req_v_r;
  assign req_store_o = store_r;
  assign req_addr_o = addr_r;
  assign req_data_o = data_r;
  assign pkt_v_o = out_v_r;

  always_comb begin
    pkt_o = '0;
    pkt_o[link_data_lsb +: $bits(data_t)] = out_data_r;
    pkt_o[link_addr_lsb +: $bits(word_addr_t)] = addr_r;
    pkt_o[link_src_lsb +: $bits(cord_y_t)] = my_y_i;
    pkt_o[link_dst_lsb +: $bits(cord_y_t)] = src_r;
    pkt_o[link_store_bit] = store_r;
    pkt_o[link_resp_bit] = 1'b1;
  end

endmodule

// ==== rtl/vcache_mesh_node.sv ====
/*
 * vertical mesh node
 * routes north, south and local traffic through one register per output
 */
`timescale 1ns/100ps

module vcache_mesh_node
  import vcache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  cord_y_t   my_y_i,

  input  logic      link_n_v_i,
  input  link_pkt_t link_n_pkt_i,
  output logic      link_n_ready_o,
  output logic      link_n_v_o,
  output link_pkt_t link_n_pkt_o,
  input  logic      link_n_ready_i,

  input  logic      link_s_v_i,
  input  link_pkt_t link_s_pkt_i,
  output logic      link_s_ready_o,
  output logic      link_s_v_o,
  output link_pkt_t link_s_pkt_o,
  input  logic      link_s_ready_i,

  output logic      proc_v_o,
  output link_pkt_t proc_pkt_o,
  input  logic      proc_ready_i,
  input  logic      proc_v_i,
  input  link_pkt_t proc_pkt_i,
  output logic      proc_ready_o
);

  logic n_v_r, s_v_r, p_v_r;
  link_pkt_t n_pkt_r, s_pkt_r, p_pkt_r;
  logic n_local, s_local, p_north;
  logic n_go, s_go, p_go;
  logic n_load, s_load, p_load;

  assign n_local = cord_y_t'(link_n_pkt_i[link_dst_lsb +: $bits(cord_y_t)]) == my_y_i;
  assign s_local = cord_y_t'(link_s_pkt_i[link_dst_lsb +: $bits(cord_y_t)]) == my_y_i;
  assign p_north = cord_y_t'(proc_pkt_i[link_dst_lsb +: $bits(cord_y_t)]) < my_y_i;

  // north wins the proc register over south
  assign link_n_ready_o = n_local ? !p_v_r : !s_v_r;
  assign link_s_ready_o = s_local ? (!p_v_r && !(link_n_v_i && n_local)) : !n_v_r;
  // local responses yield to forwarded packets
  assign proc_ready_o = p_north ? (!n_v_r && !(link_s_v_i && !s_local))
                                : (!s_v_r && !(link_n_v_i && !n_local));

  assign n_go = link_n_v_i && link_n_ready_o;
  assign s_go = link_s_v_i && link_s_ready_o;
  assign p_go = proc_v_i && proc_ready_o;

  assign n_load = (s_go && !s_local) || (p_go && p_north);
  assign s_load = (n_go && !n_local) || (p_go && !p_north);
  assign p_load = (n_go && n_local) || (s_go && s_local);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      n_v_r <= 1'b0;
      s_v_r <= 1'b0;
      p_v_r <= 1'b0;
    end else begin
      n_v_r <= n_load || (n_v_r && !link_n_ready_i);
      s_v_r <= s_load || (s_v_r && !link_s_ready_i);
      p_v_r <= p_load || (p_v_r && !proc_ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (n_load) begin
      n_pkt_r <= (s_go && !s_local) ? link_s_pkt_i : proc_pkt_i;
    end
    if (s_load) begin
      s_pkt_r <= (n_go && !n_local) ? link_n_pkt_i : proc_pkt_i;
    end
    if (p_load) begin
      p_pkt_r <= (n_go && n_local) ? link_n_pkt_i : link_s_pkt_i;
    end
  end

  assign link_n_v_o = n_v_r;
  assign link_n_pkt_o = n_pkt_r;
  assign link_s_v_o = s_v_r;
  assign link_s_pkt_o = s_pkt_r;
  assign proc_v_o = p_v_r;
  assign proc_pkt_o = p_pkt_r;

  // a held packet is never replaced before its neighbor takes it
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (rst_i)
    !((n_load && n_v_r && !link_n_ready_i) || (s_load && s_v_r && !link_s_ready_i)
      || (p_load && p_v_r && !proc_ready_i)));

endmodule

// ==== rtl/vcache_pkg.sv ====
/*
 * vcache package
 * sizes, packet field offsets and shared types of the vcache tile
 */
package vcache_pkg;

  // cache geometry
  localparam int block_words = 4;
  localparam int cache_sets = 8;
  localparam int offset_bits = 2;
  localparam int index_bits = 3;
  localparam int tag_bits = 7;

  // memory controller columns on the wormhole row
  localparam int mem_east_cord = 15;
  localparam int mem_west_cord = 0;

  typedef logic [31:0] data_t;
  typedef logic [11:0] word_addr_t;
  typedef logic [9:0] block_addr_t;
  typedef logic [3:0] cord_y_t;
  typedef logic [3:0] cord_x_t;
  typedef logic [53:0] link_pkt_t;
  typedef logic [31:0] flit_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [offset_bits-1:0] offset_t;

  // mesh packet fields, low bit up
  localparam int link_data_lsb = 0;
  localparam int link_addr_lsb = 32;
  localparam int link_src_lsb = 44;
  localparam int link_dst_lsb = 48;
  localparam int link_store_bit = 52;
  localparam int link_resp_bit = 53;

  // wormhole header fields, dest column in bits 3:0
  localparam int flit_len_lsb = 4;
  localparam int flit_cid_bit = 8;
  localparam int flit_write_bit = 9;
  localparam int flit_addr_lsb = 10;

  typedef enum logic [2:0] {c_idle, c_lookup, c_evict, c_fill, c_respond} cache_state_e;
  typedef enum logic [2:0] {d_idle, d_header, d_wdata, d_rdata, d_done} dma_state_e;

endpackage

// ==== rtl/vcache_tile.sv ====
/*
 * vcache tile top
 * registers reset and coordinates, joins mesh node, cache and DMA adapter
 */
`timescale 1ns/100ps

module vcache_tile
  import vcache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  cord_x_t   global_x_i,
  input  cord_y_t   global_y_i,
  output logic      reset_o,
  output cord_x_t   global_x_o,
  output cord_y_t   global_y_o,

  input  logic      link_n_v_i,
  input  link_pkt_t link_n_pkt_i,
  output logic      link_n_ready_o,
  output logic      link_n_v_o,
  output link_pkt_t link_n_pkt_o,
  input  logic      link_n_ready_i,
  input  logic      link_s_v_i,
  input  link_pkt_t link_s_pkt_i,
  output logic      link_s_ready_o,
  output logic      link_s_v_o,
  output link_pkt_t link_s_pkt_o,
  input  logic      link_s_ready_i,

  output logic      wh_e_v_o,
  output flit_t     wh_e_flit_o,
  input  logic      wh_e_ready_i,
  input  logic      wh_e_v_i,
  input  flit_t     wh_e_flit_i,
  output logic      wh_e_ready_o,
  output logic      wh_w_v_o,
  output flit_t     wh_w_flit_o,
  input  logic      wh_w_ready_i,
  input  logic      wh_w_v_i,
  input  flit_t     wh_w_flit_i,
  output logic      wh_w_ready_o
);

  logic rst_r;
  cord_x_t x_r;
  cord_y_t y_r;

  always_ff @(posedge clk_i) begin
    rst_r <= rst_i;
    x_r <= global_x_i;
    y_r <= global_y_i;
  end

  assign reset_o = rst_r;
  assign global_x_o = x_r;
  // next tile down the column sees y plus one
  assign global_y_o = cord_y_t'(y_r + 1'b1);

  // node to adapter and back
  logic to_l2c_v, to_l2c_ready, from_l2c_v, from_l2c_ready;
  link_pkt_t to_l2c_pkt, from_l2c_pkt;
  logic req_v, req_store, req_yumi, resp_v, resp_yumi;
  word_addr_t req_addr;
  data_t req_data, resp_data;
  logic dma_v, dma_write, dma_yumi, dma_wdata_yumi, dma_rdata_v;
  block_addr_t dma_addr;
  data_t dma_wdata, dma_rdata;

  vcache_mesh_node u_mesh_node (
    .clk_i(clk_i), .rst_i(rst_r), .my_y_i(y_r),
    .link_n_v_i(link_n_v_i), .link_n_pkt_i(link_n_pkt_i), .link_n_ready_o(link_n_ready_o),
    .link_n_v_o(link_n_v_o), .link_n_pkt_o(link_n_pkt_o), .link_n_ready_i(link_n_ready_i),
    .link_s_v_i(link_s_v_i), .link_s_pkt_i(link_s_pkt_i), .link_s_ready_o(link_s_ready_o),
    .link_s_v_o(link_s_v_o), .link_s_pkt_o(link_s_pkt_o), .link_s_ready_i(link_s_ready_i),
    .proc_v_o(to_l2c_v), .proc_pkt_o(to_l2c_pkt), .proc_ready_i(to_l2c_ready),
    .proc_v_i(from_l2c_v), .proc_pkt_i(from_l2c_pkt), .proc_ready_o(from_l2c_ready)
  );

  vcache_link_to_cache u_link_to_cache (
    .clk_i(clk_i), .rst_i(rst_r), .my_y_i(y_r),
    .pkt_v_i(to_l2c_v), .pkt_i(to_l2c_pkt), .pkt_ready_o(to_l2c_ready),
    .pkt_v_o(from_l2c_v), .pkt_o(from_l2c_pkt), .pkt_ready_i(from_l2c_ready),
    .req_v_o(req_v), .req_store_o(req_store), .req_addr_o(req_addr),
    .req_data_o(req_data), .req_yumi_i(req_yumi),
    .resp_v_i(resp_v), .resp_data_i(resp_data), .resp_yumi_o(resp_yumi)
  );

  vcache_cache u_cache (
    .clk_i(clk_i), .rst_i(rst_r),
    .req_v_i(req_v), .req_store_i(req_store), .req_addr_i(req_addr),
    .req_data_i(req_data), .req_yumi_o(req_yumi),
    .resp_v_o(resp_v), .resp_data_o(resp_data), .resp_yumi_i(resp_yumi),
    .dma_v_o(dma_v), .dma_write_o(dma_write), .dma_addr_o(dma_addr), .dma_yumi_i(dma_yumi),
    .dma_wdata_o(dma_wdata), .dma_wdata_yumi_i(dma_wdata_yumi),
    .dma_rdata_v_i(dma_rdata_v), .dma_rdata_i(dma_rdata)
  );

  // cid tells the north and south caches apart
  vcache_dma_to_wormhole u_dma_to_wormhole (
    .clk_i(clk_i), .rst_i(rst_r), .my_x_i(x_r), .my_cid_i(~y_r[0]),
    .dma_v_i(dma_v), .dma_write_i(dma_write), .dma_addr_i(dma_addr), .dma_yumi_o(dma_yumi),
    .dma_wdata_i(dma_wdata), .dma_wdata_yumi_o(dma_wdata_yumi),
    .dma_rdata_v_o(dma_rdata_v), .dma_rdata_o(dma_rdata),
    .wh_e_v_o(wh_e_v_o), .wh_e_flit_o(wh_e_flit_o), .wh_e_ready_i(wh_e_ready_i),
    .wh_e_v_i(wh_e_v_i), .wh_e_flit_i(wh_e_flit_i), .wh_e_ready_o(wh_e_ready_o),
    .wh_w_v_o(wh_w_v_o), .wh_w_flit_o(wh_w_flit_o), .wh_w_ready_i(wh_w_ready_i),
    .wh_w_v_i(wh_w_v_i), .wh_w_flit_i(wh_w_flit_i), .wh_w_ready_o(wh_w_ready_o)
  );

endmodule

// ==== tests/vcache_stimulus.txt ====
// cmd: 1 request to this row, 2 pass-through, 3 random stalls, 4 dma header counts
// cmd side(0 north 1 south) store dst addr data expect, cmd 4 has reads in data, writes in expect
1 0 0 5 024 00000000 5a5a0024
1 1 0 5 848 00000000 5a5a0848
4 0 0 0 000 00000002 00000000
1 0 1 5 025 deadbeef deadbeef
1 0 0 5 025 00000000 deadbeef
4 0 0 0 000 00000002 00000000
1 1 0 5 0a4 00000000 5a5a00a4
4 0 0 0 000 00000003 00000001
1 0 0 5 025 00000000 deadbeef
1 1 0 5 026 00000000 5a5a0026
4 0 0 0 000 00000004 00000001
2 0 0 9 123 11112222 00000000
2 1 1 1 456 33334444 00000000
3 0 0 0 000 00000001 00000000
1 1 0 5 85c 00000000 5a5a085c
1 0 1 5 85d 0badf00d 0badf00d
1 1 0 5 85d 00000000 0badf00d
4 0 0 0 000 00000005 00000001
1 0 0 5 c5c 00000000 5a5a0c5c
1 1 0 5 85d 00000000 0badf00d
1 0 0 5 848 00000000 5a5a0848
4 0 0 0 000 00000007 00000002
2 0 1 c 789 55556666 00000000
2 1 0 0 abc 77778888 00000000
0 0 0 0 000 00000000 00000000

// ==== tests/vcache_tile_tb.sv ====
/*
 * vcache tile testbench
 * file-driven mesh requests against a wormhole memory controller model
 */
`timescale 1ns/100ps

module vcache_tile_tb
  import vcache_pkg::*;
();

  localparam int timeout_cycles = 2000;
  localparam int stim_cols = 7;
  localparam int stim_depth = 64;
  localparam cord_x_t tile_x = 4'd3;
  localparam cord_y_t tile_y = 4'd5;

  logic clk_i, rst_i, reset_o;
  cord_x_t global_x_i, global_x_o;
  cord_y_t global_y_i, global_y_o;
  logic link_n_v_i, link_n_ready_o, link_n_v_o, link_n_ready_i;
  logic link_s_v_i, link_s_ready_o, link_s_v_o, link_s_ready_i;
  link_pkt_t link_n_pkt_i, link_n_pkt_o, link_s_pkt_i, link_s_pkt_o;
  logic wh_e_v_o, wh_e_ready_i, wh_e_v_i, wh_e_ready_o;
  logic wh_w_v_o, wh_w_ready_i, wh_w_v_i, wh_w_ready_o;
  flit_t wh_e_flit_o, wh_e_flit_i, wh_w_flit_o, wh_w_flit_i;

  logic [31:0] stim [stim_depth*stim_cols];
  data_t mem [1 << $bits(word_addr_t)];
  link_pkt_t north_q[$], south_q[$];
  logic [31:0] lcg_r;
  logic stall_en, timed_out;
  int errors, checks, tests, rd_hdrs, wr_hdrs;

  // memory controller model state
  int wr_left, rep_left;
  word_addr_t wr_addr;
  block_addr_t rep_blk;
  logic rep_east;
  flit_t rep_flit;

  vcache_tile u_vcache_tile (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic link_pkt_t make_pkt(input logic resp, input logic store, input cord_y_t dst,
                                         input cord_y_t src, input word_addr_t addr,
                                         input data_t data);
    link_pkt_t p;
    p = '0;
    p[link_data_lsb +: $bits(data_t)] = data;
    p[link_addr_lsb +: $bits(word_addr_t)] = addr;
    p[link_src_lsb +: $bits(cord_y_t)] = src;
    p[link_dst_lsb +: $bits(cord_y_t)] = dst;
    p[link_store_bit] = store;
    p[link_resp_bit] = resp;
    return p;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  // random ready stalls only while stall_en is set
  always @(posedge clk_i) begin
    lcg_r = next_random(lcg_r);
    link_n_ready_i <= !stall_en || lcg_r[16] || lcg_r[17];
    link_s_ready_i <= !stall_en || lcg_r[18] || lcg_r[19];
    wh_e_ready_i <= !stall_en || lcg_r[20] || lcg_r[21];
    wh_w_ready_i <= !stall_en || lcg_r[22] || lcg_r[23];
  end

  // a packet seen here moves on the next rising edge
  always @(negedge clk_i) begin
    if (link_n_v_o && link_n_ready_i) north_q.push_back(link_n_pkt_o);
    if (link_s_v_o && link_s_ready_i) south_q.push_back(link_s_pkt_o);
  end

  task automatic take_flit(input logic east, input flit_t flit);
    block_addr_t blk;
    blk = flit[flit_addr_lsb +: $bits(block_addr_t)];
    if (wr_left > 0) begin
      mem[wr_addr] = flit;
      wr_addr = wr_addr + 1'b1;
      wr_left = wr_left - 1;
    end else begin
      check_value("header side", east, blk[$bits(block_addr_t)-1]);
      check_value("header column", flit[3:0], east ? mem_east_cord : mem_west_cord);
      check_value("header cid", flit[flit_cid_bit], !tile_y[0]);
      check_value("header length", flit[flit_len_lsb +: 4],
                  flit[flit_write_bit] ? block_words : 0);
      if (flit[flit_write_bit]) begin
        wr_hdrs++;
        wr_left = block_words;
        wr_addr = {blk, offset_t'(0)};
      end else begin
        // reply header goes back to the tile column with the same cid
        rd_hdrs++;
        rep_left = block_words + 1;
        rep_east = east;
        rep_blk = blk;
        rep_flit = '0;
        rep_flit[3:0] = tile_x;
        rep_flit[flit_len_lsb +: 4] = 4'(block_words);
        rep_flit[flit_cid_bit] = flit[flit_cid_bit];
        rep_flit[flit_addr_lsb +: $bits(block_addr_t)] = blk;
      end
    end
  endtask

  always @(negedge clk_i) begin
    if ((wh_e_v_i && wh_e_ready_o) || (wh_w_v_i && wh_w_ready_o)) begin
      rep_left = rep_left - 1;
      rep_flit = mem[{rep_blk, offset_t'(block_words - rep_left)}];
    end
    if (wh_e_v_o && wh_e_ready_i) take_flit(1'b1, wh_e_flit_o);
    if (wh_w_v_o && wh_w_ready_i) take_flit(1'b0, wh_w_flit_o);
  end

  always @(posedge clk_i) begin
    wh_e_v_i <= (rep_left > 0) && rep_east;
    wh_w_v_i <= (rep_left > 0) && !rep_east;
    wh_e_flit_i <= rep_flit;
    wh_w_flit_i <= rep_flit;
  end

  task automatic send_packet(input logic south, input link_pkt_t pkt);
    int n;
    n = 0;
    @(posedge clk_i);
    if (south) begin
      link_s_v_i <= 1'b1;
      link_s_pkt_i <= pkt;
    end else begin
      link_n_v_i <= 1'b1;
      link_n_pkt_i <= pkt;
    end
    @(negedge clk_i);
    while (!timed_out && !(south ? link_s_ready_o : link_n_ready_o)) begin
      if (n >= timeout_cycles) report_timeout("mesh input ready");
      @(negedge clk_i);
      n++;
    end
    @(posedge clk_i);
    link_n_v_i <= 1'b0;
    link_s_v_i <= 1'b0;
  endtask

  task automatic wait_packet(input logic south, output link_pkt_t pkt);
    int n;
    n = 0;
    pkt = '0;
    while (!timed_out && (south ? south_q.size() : north_q.size()) == 0) begin
      if (n >= timeout_cycles) report_timeout(south ? "south output" : "north output");
      @(posedge clk_i);
      n++;
    end
    if (!timed_out) begin
      if (south) pkt = south_q.pop_front();
      else pkt = north_q.pop_front();
    end
  endtask

  // request rows sit on the side they enter from
  task automatic run_link(input logic [31:0] cmd, input logic south, input logic store,
                          input cord_y_t dst, input word_addr_t addr, input data_t data,
                          input data_t exp);
    link_pkt_t sent, got;
    cord_y_t src;
    src = south ? 4'd9 : 4'd2;
    sent = make_pkt(1'b0, store, dst, src, addr, data);
    send_packet(south, sent);
    if (cmd == 1) begin
      wait_packet(south, got);
      if (!timed_out) check_value("response packet", got,
                                  make_pkt(1'b1, store, src, tile_y, addr, exp));
    end else begin
      wait_packet(!south, got);
      if (!timed_out) check_value("passed packet", got, sent);
    end
  endtask

  initial begin
    int t, row, err0;
    clk_i = 1'b0;
    rst_i = 1'b1;
    global_x_i = '0;
    global_y_i = '0;
    link_n_v_i = 1'b0;
    link_s_v_i = 1'b0;
    link_n_pkt_i = '0;
    link_s_pkt_i = '0;
    link_n_ready_i = 1'b1;
    link_s_ready_i = 1'b1;
    wh_e_ready_i = 1'b1;
    wh_w_ready_i = 1'b1;
    wh_e_v_i = 1'b0;
    wh_w_v_i = 1'b0;
    wh_e_flit_i = '0;
    wh_w_flit_i = '0;
    lcg_r = 32'd63;
    stall_en = 1'b0;
    timed_out = 1'b0;
    for (int a = 0; a < (1 << $bits(word_addr_t)); a++) begin
      mem[a] = data_t'(a) ^ 32'h5a5a0000;
    end
    $readmemh("tests/vcache_stimulus.txt", stim);

    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    global_x_i <= tile_x;
    global_y_i <= tile_y;
    // outputs still show the coordinates from before the change
    @(negedge clk_i);
    check_value("reset_o", reset_o, 1'b1);
    check_value("global_x_o", global_x_o, 4'd0);
    check_value("global_y_o", global_y_o, 4'd1);
    @(negedge clk_i);
    check_value("reset_o", reset_o, 1'b0);
    check_value("global_x_o", global_x_o, tile_x);
    check_value("global_y_o", global_y_o, cord_y_t'(tile_y + 1));
    @(negedge clk_i);
    check_value("link_n_v_o", link_n_v_o, 1'b0);
    check_value("link_s_v_o", link_s_v_o, 1'b0);
    check_value("wh_e_v_o", wh_e_v_o, 1'b0);
    check_value("wh_w_v_o", wh_w_v_o, 1'b0);
    check_value("wh_e_ready_o", wh_e_ready_o, 1'b0);
    check_value("wh_w_ready_o", wh_w_ready_o, 1'b0);
    tests++;
    $display("test feedthrough %s", (errors == 0) ? "ok" : "failed");

    t = 0;
    while (!timed_out && t < stim_depth && stim[t*stim_cols] inside {[1:4]}) begin
      row = t * stim_cols;
      err0 = errors;
      case (stim[row])
        1, 2: begin
          run_link(stim[row], stim[row+1][0], stim[row+2][0], cord_y_t'(stim[row+3]),
                   word_addr_t'(stim[row+4]), stim[row+5], stim[row+6]);
        end
        3: begin
          @(negedge clk_i);
          stall_en = stim[row+5][0];
        end
        default: begin
          check_value("read headers", rd_hdrs, stim[row+5]);
          check_value("write headers", wr_hdrs, stim[row+6]);
        end
      endcase
      if (!timed_out) begin
        check_value("north packets left", north_q.size(), 0);
        check_value("south packets left", south_q.size(), 0);
      end
      tests++;
      $display("test %0d cmd %0d %s", t, stim[row], (errors == err0) ? "ok" : "failed");
      t++;
    end
    if (!timed_out && t == 0) begin
      errors++;
      $display("No stimulus commands were read from the stimulus file");
    end

    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vcache_tile.f ====
rtl/vcache_pkg.sv
rtl/vcache_mesh_node.sv
rtl/vcache_link_to_cache.sv
rtl/vcache_cache.sv
rtl/vcache_dma_to_wormhole.sv
rtl/vcache_tile.sv
tests/vcache_tile_tb.sv
